/* build.f */
rtl/soc_pkg.sv
rtl/dbus_if.sv
rtl/dbus_interconnect.sv
rtl/clint.sv
rtl/plic.sv
rtl/uart_tx.sv
rtl/periph_top.sv
tests/tb_clk_gen.sv
tests/periph_monitor.sv
tests/periph_chk.sv
tests/periph_tb.sv

/* rtl/clint.sv */
`timescale 1ns/1ps

module clint (
    input  logic    clk,
    input  logic    arst_n_i,

    dbus_if.slave   bus,

    output logic    timer_irq_o,
    output logic    soft_irq_o
);
    import soc_pkg::*;

    logic [2*DATA_W-1:0] mtime_q;
    logic [2*DATA_W-1:0] mtimecmp_q;
    logic                msip_q;
    logic                ack_q;
    logic [DATA_W-1:0]   rdat_q;
    logic [DATA_W-1:0]   rd_mux;
    logic                req;
    logic                wr;

    assign req = bus.cyc && bus.stb && !ack_q;  // First cycle of an access
    assign wr  = req && bus.we;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1;     // No timer interrupt out of reset
            msip_q     <= 1'b0;
            ack_q      <= 1'b0;
        end else begin
            ack_q   <= req;
            mtime_q <= mtime_q + 1'b1;

            // A word write replaces that half of the running count
            if (wr) begin
                case (bus.adr)
                    CLINT_MSIP:        msip_q                   <= bus.wdat[0];
                    CLINT_MTIMECMP_LO: mtimecmp_q[DATA_W-1:0]   <= bus.wdat;
                    CLINT_MTIMECMP_HI: mtimecmp_q[2*DATA_W-1:DATA_W] <= bus.wdat;
                    CLINT_MTIME_LO:    mtime_q[DATA_W-1:0]      <= bus.wdat;
                    CLINT_MTIME_HI:    mtime_q[2*DATA_W-1:DATA_W] <= bus.wdat;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        rd_mux = '0;
        case (bus.adr)
            CLINT_MSIP:        rd_mux[0] = msip_q;
            CLINT_MTIMECMP_LO: rd_mux    = mtimecmp_q[DATA_W-1:0];
            CLINT_MTIMECMP_HI: rd_mux    = mtimecmp_q[2*DATA_W-1:DATA_W];
            CLINT_MTIME_LO:    rd_mux    = mtime_q[DATA_W-1:0];
            CLINT_MTIME_HI:    rd_mux    = mtime_q[2*DATA_W-1:DATA_W];
            default: ;
        endcase
    end

    // Read data captured on the edge that raises ack
    always_ff @(posedge clk) begin
        if (req) begin
            rdat_q <= rd_mux;
        end
    end

    assign bus.ack  = ack_q;
    assign bus.rdat = rdat_q;

    assign timer_irq_o = (mtime_q >= mtimecmp_q);
    assign soft_irq_o  = msip_q;

endmodule : clint

/* rtl/dbus_if.sv */
`timescale 1ns/1ps

interface dbus_if;
    import soc_pkg::*;

    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;    // Offset within the region
    logic [DATA_W-1:0] wdat;
    logic [DATA_W-1:0] rdat;
    logic              ack;

    // Interconnect side
    modport master (
        output cyc, stb, we, adr, wdat,
        input  rdat, ack
    );

    // Peripheral side
    modport slave (
        input  cyc, stb, we, adr, wdat,
        output rdat, ack
    );

endinterface : dbus_if

/* rtl/dbus_interconnect.sv */
`timescale 1ns/1ps

module dbus_interconnect (
    input  logic                        clk,
    input  logic                        arst_n_i,

    input  logic                        wb_cyc_i,
    input  logic                        wb_stb_i,
    input  logic                        wb_we_i,
    input  logic [soc_pkg::ADDR_W-1:0]  wb_adr_i,
    input  logic [soc_pkg::DATA_W-1:0]  wb_dat_i,
    output logic [soc_pkg::DATA_W-1:0]  wb_dat_o,
    output logic                        wb_ack_o,

    dbus_if.master                      clint_bus,
    dbus_if.master                      plic_bus,
    dbus_if.master                      uart_bus
);
    import soc_pkg::*;

    slave_sel_e        sel;
    logic [ADDR_W-1:0] offset;
    logic              none_ack_q;   // Ack for unmapped regions

    // Region decode
    always_comb begin
        case (wb_adr_i[ADDR_W-1:RGN_LSB])
            CLINT_BASE[ADDR_W-1:RGN_LSB]: sel = SEL_CLINT;
            PLIC_BASE[ADDR_W-1:RGN_LSB]:  sel = SEL_PLIC;
            UART_BASE[ADDR_W-1:RGN_LSB]:  sel = SEL_UART;
            default:                      sel = SEL_NONE;
        endcase
    end

    assign offset = {{(ADDR_W-RGN_LSB){1'b0}}, wb_adr_i[RGN_LSB-1:0]};

    assign clint_bus.cyc  = wb_cyc_i && (sel == SEL_CLINT);
    assign clint_bus.stb  = wb_stb_i && (sel == SEL_CLINT);
    assign clint_bus.we   = wb_we_i;
    assign clint_bus.adr  = offset;
    assign clint_bus.wdat = wb_dat_i;

    assign plic_bus.cyc   = wb_cyc_i && (sel == SEL_PLIC);
    assign plic_bus.stb   = wb_stb_i && (sel == SEL_PLIC);
    assign plic_bus.we    = wb_we_i;
    assign plic_bus.adr   = offset;
    assign plic_bus.wdat  = wb_dat_i;

    assign uart_bus.cyc   = wb_cyc_i && (sel == SEL_UART);
    assign uart_bus.stb   = wb_stb_i && (sel == SEL_UART);
    assign uart_bus.we    = wb_we_i;
    assign uart_bus.adr   = offset;
    assign uart_bus.wdat  = wb_dat_i;

    // Unmapped access answered after one cycle so the master never hangs
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            none_ack_q <= 1'b0;
        end else begin
            none_ack_q <= wb_cyc_i && wb_stb_i && (sel == SEL_NONE) && !none_ack_q;
        end
    end

    // Response mux back to the top
    always_comb begin
        case (sel)
            SEL_CLINT: begin
                wb_dat_o = clint_bus.rdat;
                wb_ack_o = clint_bus.ack;
            end
            SEL_PLIC: begin
                wb_dat_o = plic_bus.rdat;
                wb_ack_o = plic_bus.ack;
            end
            SEL_UART: begin
                wb_dat_o = uart_bus.rdat;
                wb_ack_o = uart_bus.ack;
            end
            default: begin
                wb_dat_o = '0;          // Unmapped reads return zero
                wb_ack_o = none_ack_q;
            end
        endcase
    end

endmodule : dbus_interconnect

/* rtl/periph_top.sv */
`timescale 1ns/1ps

module periph_top (
    input  logic                        clk,
    input  logic                        arst_n_i,

    // Wishbone slave port from the load/store unit
    input  logic                        wb_cyc_i,
    input  logic                        wb_stb_i,
    input  logic                        wb_we_i,
    input  logic [soc_pkg::ADDR_W-1:0]  wb_adr_i,
    input  logic [soc_pkg::DATA_W-1:0]  wb_dat_i,
    output logic [soc_pkg::DATA_W-1:0]  wb_dat_o,
    output logic                        wb_ack_o,

    input  logic                        ext_irq_i,

    output logic                        uart_txd_o,
    output logic                        timer_irq_o,
    output logic                        soft_irq_o,
    output logic                        ext_irq_o
);

    logic uart_irq;

    dbus_if clint_bus ();
    dbus_if plic_bus ();
    dbus_if uart_bus ();

    dbus_interconnect i_dbus_interconnect (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_we_i    (wb_we_i),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_o   (wb_ack_o),
        .clint_bus  (clint_bus.master),
        .plic_bus   (plic_bus.master),
        .uart_bus   (uart_bus.master)
    );

    clint i_clint (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .bus         (clint_bus.slave),
        .timer_irq_o (timer_irq_o),
        .soft_irq_o  (soft_irq_o)
    );

    plic i_plic (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .bus        (plic_bus.slave),
        .src_irq_i  ({ext_irq_i, uart_irq}),   // Source 2 external, source 1 UART
        .irq_o      (ext_irq_o)
    );

    uart_tx i_uart_tx (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .bus        (uart_bus.slave),
        .txd_o      (uart_txd_o),
        .irq_o      (uart_irq)
    );

endmodule : periph_top

/* rtl/plic.sv */
`timescale 1ns/1ps

module plic (
    input  logic                           clk,
    input  logic                           arst_n_i,

    dbus_if.slave                          bus,

    input  logic [soc_pkg::PLIC_SRC_N-1:0] src_irq_i,   // Bit 0 is source 1
    output logic                           irq_o
);
    import soc_pkg::*;

    logic [PLIC_SRC_N:1][PLIC_PRIO_W-1:0] prio_q;
    logic [PLIC_SRC_N:1]                  pending_q;
    logic [PLIC_SRC_N:1]                  enable_q;
    logic [PLIC_SRC_N:1]                  in_service_q;
    logic [PLIC_PRIO_W-1:0]               threshold_q;
    logic [PLIC_PRIO_W-1:0]               best_prio;
    logic [PLIC_ID_W-1:0]                 best_id;
    logic                                 irq_q;
    logic                                 ack_q;
    logic [DATA_W-1:0]                    rdat_q;
    logic [DATA_W-1:0]                    rd_mux;
    logic                                 req;
    logic                                 wr;
    logic                                 claim;
    logic                                 complete;

    assign req      = bus.cyc && bus.stb && !ack_q;
    assign wr       = req && bus.we;
    assign claim    = req && !bus.we && (bus.adr == PLIC_CLAIM);
    assign complete = wr && (bus.adr == PLIC_CLAIM);

    // Strict compare keeps the lower id on a tie and enforces the threshold
    always_comb begin
        best_id   = '0;
        best_prio = threshold_q;
        for (int i = 1; i <= PLIC_SRC_N; i++) begin
            if (pending_q[i] && enable_q[i] && (prio_q[i] > best_prio)) begin
                best_id   = PLIC_ID_W'(i);
                best_prio = prio_q[i];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            prio_q       <= '0;
            pending_q    <= '0;
            enable_q     <= '0;
            in_service_q <= '0;
            threshold_q  <= '0;
            irq_q        <= 1'b0;
            ack_q        <= 1'b0;
        end else begin
            ack_q <= req;
            irq_q <= (best_id != '0);

            if (wr && (bus.adr == PLIC_THRESHOLD)) begin
                threshold_q <= bus.wdat[PLIC_PRIO_W-1:0];
            end
            if (wr && (bus.adr == PLIC_ENABLE)) begin
                enable_q <= bus.wdat[PLIC_SRC_N:1];
            end

            for (int i = 1; i <= PLIC_SRC_N; i++) begin
                if (wr && (bus.adr == PLIC_PRIO_BASE + ADDR_W'(4 * i))) begin
                    prio_q[i] <= bus.wdat[PLIC_PRIO_W-1:0];
                end

                // Level gateway
                if (claim && (best_id == PLIC_ID_W'(i))) begin
                    pending_q[i]    <= 1'b0;
                    in_service_q[i] <= 1'b1;
                end else if (src_irq_i[i-1] && !in_service_q[i]) begin
                    pending_q[i] <= 1'b1;
                end

                if (complete && (bus.wdat[PLIC_ID_W-1:0] == PLIC_ID_W'(i))) begin
                    in_service_q[i] <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        rd_mux = '0;
        case (bus.adr)
            PLIC_PENDING:   rd_mux[PLIC_SRC_N:0]    = {pending_q, 1'b0};
            PLIC_ENABLE:    rd_mux[PLIC_SRC_N:0]    = {enable_q, 1'b0};
            PLIC_THRESHOLD: rd_mux[PLIC_PRIO_W-1:0] = threshold_q;
            PLIC_CLAIM:     rd_mux[PLIC_ID_W-1:0]   = best_id;
            default: begin
                for (int i = 1; i <= PLIC_SRC_N; i++) begin
                    if (bus.adr == PLIC_PRIO_BASE + ADDR_W'(4 * i)) begin
                        rd_mux[PLIC_PRIO_W-1:0] = prio_q[i];
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (req) begin
            rdat_q <= rd_mux;   // Claim id sampled with its side effects
        end
    end

    assign bus.ack  = ack_q;
    assign bus.rdat = rdat_q;
    assign irq_o    = irq_q;

endmodule : plic

/* rtl/soc_pkg.sv */
package soc_pkg;

    // Bus widths
    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;

    // Region decode uses address bits 31..24
    localparam int RGN_LSB = 24;

    localparam logic [ADDR_W-1:0] CLINT_BASE = 32'h0200_0000;
    localparam logic [ADDR_W-1:0] PLIC_BASE  = 32'h0C00_0000;
    localparam logic [ADDR_W-1:0] UART_BASE  = 32'h1000_0000;

    // CLINT register offsets
    localparam logic [ADDR_W-1:0] CLINT_MSIP        = 32'h0000_0000;
    localparam logic [ADDR_W-1:0] CLINT_MTIMECMP_LO = 32'h0000_4000;
    localparam logic [ADDR_W-1:0] CLINT_MTIMECMP_HI = 32'h0000_4004;
    localparam logic [ADDR_W-1:0] CLINT_MTIME_LO    = 32'h0000_BFF8;
    localparam logic [ADDR_W-1:0] CLINT_MTIME_HI    = 32'h0000_BFFC;

    // PLIC register offsets, priority of source n at PRIO_BASE + 4*n
    localparam logic [ADDR_W-1:0] PLIC_PRIO_BASE = 32'h0000_0000;
    localparam logic [ADDR_W-1:0] PLIC_PENDING   = 32'h0000_1000;
    localparam logic [ADDR_W-1:0] PLIC_ENABLE    = 32'h0000_2000;
    localparam logic [ADDR_W-1:0] PLIC_THRESHOLD = 32'h0020_0000;
    localparam logic [ADDR_W-1:0] PLIC_CLAIM     = 32'h0020_0004;

    localparam int PLIC_SRC_N  = 2;   // Source 1 UART, source 2 external
    localparam int PLIC_PRIO_W = 3;
    localparam int PLIC_ID_W   = $clog2(PLIC_SRC_N + 1);

    // UART register offsets
    localparam logic [ADDR_W-1:0] UART_TXDATA = 32'h0000_0000;
    localparam logic [ADDR_W-1:0] UART_STATUS = 32'h0000_0004;
    localparam logic [ADDR_W-1:0] UART_DIV    = 32'h0000_0008;
    localparam logic [ADDR_W-1:0] UART_IER    = 32'h0000_000C;

    localparam int UART_DIV_W      = 16;
    localparam int UART_FRAME_BITS = 10;  // Start, 8 data, stop
    localparam logic [UART_DIV_W-1:0] UART_DIV_RESET = 16'd4;

    typedef enum logic [1:0] {
        SEL_NONE,
        SEL_CLINT,
        SEL_PLIC,
        SEL_UART
    } slave_sel_e;

endpackage : soc_pkg

/* rtl/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
    input  logic    clk,
    input  logic    arst_n_i,

    dbus_if.slave   bus,

    output logic    txd_o,
    output logic    irq_o
);
    import soc_pkg::*;

    logic [UART_DIV_W-1:0]              div_q;
    logic [UART_DIV_W-1:0]              baud_cnt_q;
    logic [$clog2(UART_FRAME_BITS)-1:0] bit_cnt_q;
    logic [UART_FRAME_BITS-1:0]         shift_q;
    logic                               busy_q;
    logic                               ier_q;
    logic                               txd_q;
    logic                               ack_q;
    logic [DATA_W-1:0]                  rdat_q;
    logic                               req;
    logic                               wr;

    assign req = bus.cyc && bus.stb && !ack_q;
    assign wr  = req && bus.we;

    // Frame payload, shifted out LSB first
    always_ff @(posedge clk) begin
        if (wr && (bus.adr == UART_TXDATA) && !busy_q) begin
            shift_q <= {1'b1, bus.wdat[7:0], 1'b0};
        end else if (busy_q && (baud_cnt_q == div_q - 1'b1)) begin
            shift_q <= {1'b1, shift_q[UART_FRAME_BITS-1:1]};
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            div_q      <= UART_DIV_RESET;
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
            busy_q     <= 1'b0;
            ier_q      <= 1'b0;
            txd_q      <= 1'b1;    // Line idles high
            ack_q      <= 1'b0;
        end else begin
            ack_q <= req;
            txd_q <= busy_q ? shift_q[0] : 1'b1;   // One cycle behind the shifter

            if (wr && (bus.adr == UART_DIV)) div_q <= bus.wdat[UART_DIV_W-1:0];
            if (wr && (bus.adr == UART_IER)) ier_q <= bus.wdat[0];

            if (wr && (bus.adr == UART_TXDATA) && !busy_q) begin
                busy_q     <= 1'b1;
                baud_cnt_q <= '0;
                bit_cnt_q  <= '0;
            end else if (busy_q) begin
                if (baud_cnt_q == div_q - 1'b1) begin
                    baud_cnt_q <= '0;
                    bit_cnt_q  <= bit_cnt_q + 1'b1;
                    if (bit_cnt_q == UART_FRAME_BITS - 1) begin
                        busy_q <= 1'b0;   // Stop bit done
                    end
                end else begin
                    baud_cnt_q <= baud_cnt_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            rdat_q <= '0;
            case (bus.adr)
                UART_STATUS: rdat_q[0]              <= busy_q;
                UART_DIV:    rdat_q[UART_DIV_W-1:0] <= div_q;
                UART_IER:    rdat_q[0]              <= ier_q;
                default: ;
            endcase
        end
    end

    assign bus.ack  = ack_q;
    assign bus.rdat = rdat_q;
    assign txd_o    = txd_q;
    assign irq_o    = ier_q && !busy_q;

endmodule : uart_tx

/* tests/periph_chk.sv */
`timescale 1ns/1ps

module periph_chk (
    input logic clk,
    input logic arst_n_i,
    input logic wb_stb_i,
    input logic wb_ack_o,
    input logic uart_txd_o,
    input logic timer_irq_o,
    input logic soft_irq_o,
    input logic ext_irq_o
);

    int fail_cnt = 0;   // Failed assertions so far

    // Every ack lasts a single cycle
    ack_one_cycle: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_ack_o |=> !wb_ack_o)
        else begin
            fail_cnt++;
            $error("ack held high for two cycles");
        end

    ack_after_stb: assert property (@(posedge clk) disable iff (!arst_n_i)
        $rose(wb_ack_o) |-> $past(wb_stb_i))
        else begin
            fail_cnt++;
            $error("ack rose without a preceding strobe");
        end

    // Outputs settle inactive once reset has been seen on a full cycle
    reset_outputs: assert property (@(posedge clk)
        (!arst_n_i && $past(!arst_n_i)) |->
            (uart_txd_o && !timer_irq_o && !soft_irq_o && !ext_irq_o))
        else begin
            fail_cnt++;
            $error("outputs active while in reset");
        end

endmodule : periph_chk

bind periph_top periph_chk i_periph_chk (.*);

/* tests/periph_monitor.sv */
`timescale 1ns/1ps

module periph_monitor (
    input  logic        clk,
    input  logic        arst_n_i,
    input  logic        wb_we_i,
    input  logic [31:0] wb_adr_i,
    input  logic [31:0] wb_dat_o,
    input  logic        wb_ack_o,
    input  logic        uart_txd_o,
    input  logic        timer_irq_o,
    input  logic        soft_irq_o,
    input  logic        ext_irq_o,
    input  int          test_i,
    input  logic        cmp_i,        // Compare read data
    input  logic        rec_i,        // Remember mtime
    input  logic        gt_i,         // Expect a larger mtime
    input  logic [31:0] exp_data_i,
    input  logic [31:0] exp_mask_i,
    input  logic [2:0]  irq_exp_i,    // {ext, timer, soft}
    input  logic [2:0]  irq_care_i,
    input  logic        done_i,
    output int          err_cnt_o
);
    import soc_pkg::*;

    int          test_errs = 0;
    int          total_errs = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          last_test = 0;
    int          frames = 0;
    bit          closed = 0;
    logic [31:0] mtime_prev = '0;

    assign err_cnt_o = total_errs;

    function automatic slave_sel_e region_of(logic [31:0] adr);
        if (adr[31:24] == CLINT_BASE[31:24]) return SEL_CLINT;
        if (adr[31:24] == PLIC_BASE[31:24])  return SEL_PLIC;
        if (adr[31:24] == UART_BASE[31:24])  return SEL_UART;
        return SEL_NONE;
    endfunction

    task automatic report(string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        test_errs++;
        total_errs++;
    endtask

    task automatic finish_test();
        if (last_test == 3 && frames != 1)
            report($sformatf("expected one UART frame, saw %0d", frames));
        tests_run++;
        if (test_errs == 0) begin
            $display("Test %0d: passed", last_test);
        end else begin
            $display("Test %0d: failed with %0d errors", last_test, test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    task automatic check_access();
        logic [2:0] irq_now;
        slave_sel_e rgn;
        irq_now = {ext_irq_o, timer_irq_o, soft_irq_o};
        rgn     = region_of(wb_adr_i);
        if (((irq_now ^ irq_exp_i) & irq_care_i) != 3'b000)
            report($sformatf("test %0d irq outputs %b, expected %b (care %b)",
                             test_i, irq_now, irq_exp_i, irq_care_i));
        if (!wb_we_i) begin
            if (rec_i) begin
                mtime_prev = wb_dat_o;
            end else if (gt_i) begin
                if (!(wb_dat_o > mtime_prev))
                    report($sformatf("mtime 0x%08h not above 0x%08h", wb_dat_o, mtime_prev));
            end else if (cmp_i && (((wb_dat_o ^ exp_data_i) & exp_mask_i) != '0)) begin
                report($sformatf("%s read at 0x%08h returned 0x%08h, expected 0x%08h",
                                 rgn.name(), wb_adr_i, wb_dat_o, exp_data_i));
            end
        end
    endtask

    always @(posedge clk) begin
        if (arst_n_i) begin
            if (test_i != last_test) begin
                if (last_test > 0) finish_test();
                last_test = test_i;
            end
            if (wb_ack_o) check_access();
            if (done_i && !closed) begin
                closed = 1;
                $display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
                         tests_run, tests_run - tests_failed, tests_failed, total_errs);
            end
        end
    end

    initial begin
        @(posedge arst_n_i);
        @(posedge clk);
        if (uart_txd_o !== 1'b1 || wb_ack_o !== 1'b0
                || {ext_irq_o, timer_irq_o, soft_irq_o} !== 3'b000)
            report("outputs not inactive after reset");
    end

    // UART frame decoder, samples near the middle of each bit
    initial begin
        logic [7:0] data;
        forever begin
            @(negedge uart_txd_o);
            if (arst_n_i) begin
                repeat (int'(UART_DIV_RESET) / 2) @(posedge clk);
                if (uart_txd_o !== 1'b0) report("UART start bit not low at mid bit");
                for (int i = 0; i < 8; i++) begin
                    repeat (int'(UART_DIV_RESET)) @(posedge clk);
                    data[i] = uart_txd_o;
                end
                repeat (int'(UART_DIV_RESET)) @(posedge clk);
                if (uart_txd_o !== 1'b1) report("UART stop bit not high");
                if (data !== 8'hA5) report($sformatf("UART sent 0x%02h, expected 0xa5", data));
                frames++;
            end
        end
    end

endmodule : periph_monitor

/* tests/periph_tb.sv */
`timescale 1ns/1ps

module periph_tb;
    import soc_pkg::*;

    localparam int K_CMP  = 0;
    localparam int K_REC  = 1;
    localparam int K_GT   = 2;
    localparam int K_POLL = 3;   // Repeat until bit 0 reads zero

    typedef struct {
        int          test;
        bit          we;
        logic [31:0] adr;
        logic [31:0] wdat;
        logic [31:0] exp;
        logic [31:0] mask;
        logic [2:0]  irq_exp;
        logic [2:0]  irq_care;
        bit          ext;
        int          kind;
    } entry_t;

    entry_t      tbl[$];
    logic        clk, arst_n;
    logic        wb_cyc, wb_stb, wb_we, ext_irq, wb_ack;
    logic [31:0] wb_adr, wb_wdat, wb_rdat, rd_val;
    logic        uart_txd, timer_irq, soft_irq, ext_irq_out;
    int          cur_test = 0;
    logic        cmp_en = 0, rec_en = 0, gt_en = 0, done = 0;
    logic [31:0] exp_data = '0, exp_mask = '0;
    logic [2:0]  irq_exp = '0, irq_care = '0;
    int          err_cnt;
    int          cycles = 0;
    int          limit = 0;

    tb_clk_gen i_clk_gen (.clk_o(clk), .arst_n_o(arst_n));

    periph_top i_dut (
        .clk(clk), .arst_n_i(arst_n),
        .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
        .wb_adr_i(wb_adr), .wb_dat_i(wb_wdat), .wb_dat_o(wb_rdat), .wb_ack_o(wb_ack),
        .ext_irq_i(ext_irq), .uart_txd_o(uart_txd),
        .timer_irq_o(timer_irq), .soft_irq_o(soft_irq), .ext_irq_o(ext_irq_out)
    );

    periph_monitor i_monitor (
        .clk(clk), .arst_n_i(arst_n), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
        .wb_dat_o(wb_rdat), .wb_ack_o(wb_ack), .uart_txd_o(uart_txd),
        .timer_irq_o(timer_irq), .soft_irq_o(soft_irq), .ext_irq_o(ext_irq_out),
        .test_i(cur_test), .cmp_i(cmp_en), .rec_i(rec_en), .gt_i(gt_en),
        .exp_data_i(exp_data), .exp_mask_i(exp_mask), .irq_exp_i(irq_exp),
        .irq_care_i(irq_care), .done_i(done), .err_cnt_o(err_cnt)
    );

    task automatic add_wr(int t, logic [31:0] adr, logic [31:0] d, bit ext = 0);
        tbl.push_back('{t, 1'b1, adr, d, '0, '0, 3'b000, 3'b000, ext, K_CMP});
    endtask

    task automatic add_rd(int t, logic [31:0] adr, logic [31:0] exp, logic [31:0] mask,
                          logic [2:0] irq = 3'b000, logic [2:0] care = 3'b000,
                          bit ext = 0, int kind = K_CMP);
        tbl.push_back('{t, 1'b0, adr, '0, exp, mask, irq, care, ext, kind});
    endtask

    task automatic add_readback(int t, logic [31:0] adr, logic [31:0] mask);
        logic [31:0] r;
        r = $urandom;
        add_wr(t, adr, r);
        add_rd(t, adr, r, mask);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (limit != 0 && cycles >= limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        wb_cyc  = 1'b0;
        wb_stb  = 1'b0;
        wb_we   = 1'b0;
        wb_adr  = '0;
        wb_wdat = '0;
        ext_irq = 1'b0;
        void'($urandom(29));

        // 1: reset state, read-back, unmapped access
        add_rd(1, 32'h4000_0000, '0, '1, 3'b000, 3'b111);
        add_readback(1, UART_BASE + UART_DIV, 32'h0000_FFFF);
        add_readback(1, PLIC_BASE + PLIC_PRIO_BASE + 4, 32'h7);
        add_readback(1, PLIC_BASE + PLIC_PRIO_BASE + 8, 32'h7);
        add_readback(1, PLIC_BASE + PLIC_THRESHOLD, 32'h7);
        add_readback(1, CLINT_BASE + CLINT_MTIMECMP_LO, '1);
        add_readback(1, CLINT_BASE + CLINT_MTIMECMP_HI, '1);
        // 2: CLINT
        add_rd(2, CLINT_BASE + CLINT_MTIME_LO, '0, '0, 3'b000, 3'b000, 0, K_REC);
        add_rd(2, CLINT_BASE + CLINT_MSIP, '0, 32'h1, 3'b000, 3'b001);
        add_rd(2, CLINT_BASE + CLINT_MTIME_LO, '0, '0, 3'b000, 3'b000, 0, K_GT);
        add_wr(2, CLINT_BASE + CLINT_MTIMECMP_LO, '0);
        add_wr(2, CLINT_BASE + CLINT_MTIMECMP_HI, '0);
        add_rd(2, CLINT_BASE + CLINT_MTIMECMP_HI, '0, '1, 3'b010, 3'b010);
        add_wr(2, CLINT_BASE + CLINT_MTIMECMP_HI, '1);
        add_wr(2, CLINT_BASE + CLINT_MTIMECMP_LO, '1);
        add_rd(2, CLINT_BASE + CLINT_MTIMECMP_LO, '1, '1, 3'b000, 3'b010);
        add_wr(2, CLINT_BASE + CLINT_MSIP, 32'h1);
        add_rd(2, CLINT_BASE + CLINT_MSIP, 32'h1, 32'h1, 3'b001, 3'b001);
        add_wr(2, CLINT_BASE + CLINT_MSIP, 32'h0);
        add_rd(2, CLINT_BASE + CLINT_MSIP, 32'h0, 32'h1, 3'b000, 3'b001);
        // 3: UART frame, second write lands while busy
        add_wr(3, UART_BASE + UART_DIV, 32'd4);
        add_wr(3, UART_BASE + UART_TXDATA, 32'hA5);
        add_rd(3, UART_BASE + UART_STATUS, 32'h1, 32'h1);
        add_wr(3, UART_BASE + UART_TXDATA, 32'h3C);
        add_rd(3, UART_BASE + UART_STATUS, '0, '0, 3'b000, 3'b000, 0, K_POLL);
        add_rd(3, UART_BASE + UART_STATUS, 32'h0, 32'h1);
        // 4: PLIC single source
        add_wr(4, PLIC_BASE + PLIC_PRIO_BASE + 8, 32'd5, 1);
        add_wr(4, PLIC_BASE + PLIC_ENABLE, 32'h6, 1);
        add_wr(4, PLIC_BASE + PLIC_THRESHOLD, 32'h0, 1);
        add_rd(4, PLIC_BASE + PLIC_CLAIM, 32'd2, '1, 3'b100, 3'b100, 1);
        add_rd(4, PLIC_BASE + PLIC_ENABLE, 32'h6, 32'h6, 3'b000, 3'b100, 1);
        add_wr(4, PLIC_BASE + PLIC_CLAIM, 32'd2, 0);
        add_rd(4, PLIC_BASE + PLIC_PENDING, 32'h0, 32'h6, 3'b000, 3'b100);
        // 5: arbitration between UART and external line, then threshold
        add_wr(5, PLIC_BASE + PLIC_PRIO_BASE + 4, 32'd1);
        add_wr(5, PLIC_BASE + PLIC_PRIO_BASE + 8, 32'd3, 1);
        add_wr(5, UART_BASE + UART_IER, 32'h1, 1);
        add_rd(5, PLIC_BASE + PLIC_CLAIM, 32'd2, '1, 3'b100, 3'b100, 1);
        add_wr(5, PLIC_BASE + PLIC_CLAIM, 32'd2, 0);
        add_rd(5, PLIC_BASE + PLIC_CLAIM, 32'd1, '1);
        add_wr(5, PLIC_BASE + PLIC_CLAIM, 32'd1);
        add_wr(5, PLIC_BASE + PLIC_THRESHOLD, 32'd3);
        add_rd(5, PLIC_BASE + PLIC_CLAIM, 32'd0, '1, 3'b000, 3'b100);

        limit = tbl.size() * 8 + 12 * 10 * int'(UART_DIV_RESET) + 200;

        @(posedge arst_n);
        foreach (tbl[i]) begin
            do begin
                @(posedge clk);
                wb_cyc   <= 1'b1;
                wb_stb   <= 1'b1;
                wb_we    <= tbl[i].we;
                wb_adr   <= tbl[i].adr;
                wb_wdat  <= tbl[i].wdat;
                ext_irq  <= tbl[i].ext;
                cur_test <= tbl[i].test;
                cmp_en   <= (tbl[i].kind == K_CMP);
                rec_en   <= (tbl[i].kind == K_REC);
                gt_en    <= (tbl[i].kind == K_GT);
                exp_data <= tbl[i].exp;
                exp_mask <= tbl[i].mask;
                irq_exp  <= tbl[i].irq_exp;
                irq_care <= tbl[i].irq_care;
                @(posedge clk);
                while (!wb_ack) @(posedge clk);
                rd_val = wb_rdat;
                wb_cyc <= 1'b0;   // Strobe low for one cycle
                wb_stb <= 1'b0;
            end while (tbl[i].kind == K_POLL && rd_val[0] !== 1'b0);
        end

        @(posedge clk);
        cur_test <= 0;
        repeat (2) @(posedge clk);
        done <= 1'b1;
        repeat (2) @(posedge clk);
        if (err_cnt == 0 && i_dut.i_periph_chk.fail_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule : periph_tb

/* tests/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o    = 1'b0;
        arst_n_o = 1'b0;
        forever #50 clk_o = ~clk_o;   // 100 ns period
    end

    initial begin
        repeat (10) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule : tb_clk_gen
